/* logic/i3c_bus_pkg.sv */
// Bus-level definitions shared by the I3C target control path
// Byte and address widths, the broadcast address byte and PHY/monitor link structs
package i3c_bus_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [6:0] addr_t;

  // 7E with R/nW low
  localparam byte_t BroadcastByte = 8'hFC;

  // One-cycle strobes from the bus monitor
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_evt_t;

  // Request levels towards the bit/byte PHY
  typedef struct packed {
    logic  rx_req_byte;
    logic  rx_req_bit;
    logic  tx_req_byte;
    logic  tx_req_bit;
    byte_t tx_value;
  } phy_req_t;

  // Done pulses from the PHY, rx_data valid with rx_done
  typedef struct packed {
    logic  rx_done;
    byte_t rx_data;
    logic  tx_done;
  } phy_rsp_t;

endpackage

/* logic/i3c_target_pkg.sv */
// Target-side definitions for the I3C control path
// Address configuration, match flags, TX value source and the primary FSM states
package i3c_target_pkg;

  import i3c_bus_pkg::*;

  // Same layout serves the own and the virtual target
  typedef struct packed {
    addr_t sta_addr;
    logic  sta_valid;
    addr_t dyn_addr;
    logic  dyn_valid;
  } addr_cfg_t;

  typedef struct packed {
    logic ours;
    logic virt;
    logic bcast;
    logic rnw;
  } addr_match_t;

  // Selects what the PHY transmits
  typedef enum logic [1:0] {
    TxNone,
    TxAck,
    TxData,
    TxTbit
  } tx_src_e;

  typedef enum logic [3:0] {
    Idle,
    RxFByte,
    CheckFByte,
    TxAckFByte,
    RxSByte,
    RxSByteRepeated,
    CheckSByte,
    TxAckSByte,
    RxPWriteData,
    RxPWriteTbit,
    TxPReadData,
    TxPReadTbit,
    Wait,
    DoCCC,
    DoneCCC
  } target_state_e;

endpackage

/* logic/i3c_addr_decoder.sv */
// Address byte decoder of the I3C target
// Holds the received address and R/nW and flags own, virtual and broadcast matches
`timescale 1ns/1ps

module i3c_addr_decoder
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  byte_t       rx_data_i,
  input  logic        addr_capture_i,
  input  logic        check_f_i,
  input  logic        check_s_i,
  input  logic        idle_i,
  input  logic        start_i,
  input  addr_cfg_t   own_cfg_i,
  input  addr_cfg_t   virt_cfg_i,
  output addr_match_t match_o,
  output byte_t       last_addr_o,
  output logic        last_addr_valid_o,
  output logic        virtual_device_sel_o,
  output logic        xfer_in_progress_o
);

  addr_t addr_q;
  logic  rnw_q;
  logic  own_hit;
  logic  virt_hit;
  logic  bcast_hit;
  logic  check;

  // Dynamic address takes precedence, no valid address means no match
  function automatic logic addr_hit(addr_cfg_t cfg, addr_t addr);
    logic hit;
    hit = 1'b0;
    if (cfg.dyn_valid) begin
      hit = (cfg.dyn_addr == addr);
    end else if (cfg.sta_valid) begin
      hit = (cfg.sta_addr == addr);
    end
    return hit;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end else if (addr_capture_i) begin
      addr_q <= rx_data_i[7:1];
      rnw_q  <= rx_data_i[0];
    end else if (idle_i) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end
  end

  assign own_hit   = addr_hit(own_cfg_i, addr_q);
  assign virt_hit  = addr_hit(virt_cfg_i, addr_q);
  assign bcast_hit = ({addr_q, rnw_q} == BroadcastByte);
  assign check     = check_f_i | check_s_i;

  assign match_o.ours  = own_hit;
  assign match_o.virt  = virt_hit;
  assign match_o.bcast = bcast_hit;
  assign match_o.rnw   = rnw_q;

  assign last_addr_o = {addr_q, rnw_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_addr_valid_o    <= 1'b0;
      xfer_in_progress_o   <= 1'b0;
      virtual_device_sel_o <= 1'b0;
    end else begin
      if (start_i) begin
        last_addr_valid_o <= 1'b0;
      end else if (addr_capture_i) begin
        last_addr_valid_o <= 1'b1;
      end
      if (idle_i) begin
        xfer_in_progress_o <= 1'b0;
      end else if (check) begin
        xfer_in_progress_o <= own_hit | virt_hit;
      end
      // Broadcast byte leaves the previous selection in place
      if (check && !bcast_hit) begin
        virtual_device_sel_o <= virt_hit;
      end
    end
  end

endmodule

/* logic/i3c_rx_path.sv */
// Receive data path of the I3C target for private writes
// Captures bytes, checks the T-bit and feeds the RX FIFO write side
`timescale 1ns/1ps

module i3c_rx_path
  import i3c_bus_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  byte_t rx_data_i,
  input  logic  data_done_i,
  input  logic  tbit_done_i,
  input  logic  write_entry_i,
  input  logic  rx_clear_i,
  input  logic  rx_fifo_wready_i,
  output logic  rx_fifo_wvalid_o,
  output byte_t rx_fifo_wdata_o,
  output logic  parity_err_o,
  output logic  rx_overflow_err_o
);

  byte_t data_q;
  logic  wvalid_q;
  logic  parity_q;
  logic  ovf_q;
  logic  parity_pulse_q;
  logic  ovf_pulse_q;
  logic  tbit_ok;
  logic  ovf_hit;
  logic  write_set;

  // T-bit is odd parity over the held byte
  assign tbit_ok = (rx_data_i[0] == ~(^data_q));

  // New byte while the previous entry still waits on the FIFO
  assign ovf_hit = data_done_i & wvalid_q & ~rx_fifo_wready_i;

  assign write_set = write_entry_i & tbit_ok & ~parity_q & ~ovf_q;

  // Dropped byte must not disturb the pending entry
  always_ff @(posedge clk_i) begin
    if (data_done_i && !ovf_hit) begin
      data_q <= rx_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      parity_q       <= 1'b0;
      ovf_q          <= 1'b0;
      parity_pulse_q <= 1'b0;
      ovf_pulse_q    <= 1'b0;
      wvalid_q       <= 1'b0;
    end else begin
      if (rx_clear_i) begin
        parity_q <= 1'b0;
        ovf_q    <= 1'b0;
      end else begin
        if (tbit_done_i && !tbit_ok) begin
          parity_q <= 1'b1;
        end
        if (ovf_hit) begin
          ovf_q <= 1'b1;
        end
      end
      parity_pulse_q <= tbit_done_i & ~tbit_ok;
      ovf_pulse_q    <= ovf_hit & ~ovf_q;
      // Held until the FIFO takes it
      if (write_set) begin
        wvalid_q <= 1'b1;
      end else if (wvalid_q && rx_fifo_wready_i) begin
        wvalid_q <= 1'b0;
      end
    end
  end

  assign rx_fifo_wvalid_o  = wvalid_q;
  assign rx_fifo_wdata_o   = data_q;
  assign parity_err_o      = parity_pulse_q;
  assign rx_overflow_err_o = ovf_pulse_q;

endmodule

/* logic/i3c_tx_path.sv */
// Transmit data path of the I3C target for ACKs and private reads
// Holds the popped TX FIFO byte and forms the PHY transmit request and value
`timescale 1ns/1ps

module i3c_tx_path
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  tx_src_e tx_src_i,
  input  logic    tx_pop_i,
  input  byte_t   tx_fifo_rdata_i,
  input  logic    tx_done_i,
  input  logic    tx_last_byte_i,
  output byte_t   tx_value_o,
  output logic    tx_req_byte_o,
  output logic    tx_req_bit_o,
  output logic    end_xfer_o
);

  byte_t data_q;
  logic  end_xfer_q;

  assign tx_req_byte_o = (tx_src_i == TxData);
  assign tx_req_bit_o  = (tx_src_i == TxAck) || (tx_src_i == TxTbit);

  always_ff @(posedge clk_i) begin
    if (tx_pop_i) begin
      data_q <= tx_fifo_rdata_i;
    end
  end

  // Sampled at every bit done, so the flag of the next byte is ready for its T-bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      end_xfer_q <= 1'b0;
    end else if (tx_done_i && tx_req_bit_o) begin
      end_xfer_q <= tx_last_byte_i;
    end
  end

  always_comb begin
    case (tx_src_i)
      TxAck:   tx_value_o = 8'h00;
      TxData:  tx_value_o = data_q;
      TxTbit:  tx_value_o = {7'b0, ~end_xfer_q};
      default: tx_value_o = 8'h01;
    endcase
  end

  assign end_xfer_o = end_xfer_q;

endmodule

/* logic/i3c_target_fsm.sv */
// Primary state machine of the I3C target
// Sequences address, ACK, private read/write data, T-bit and CCC hand-off phases
`timescale 1ns/1ps

module i3c_target_fsm
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        target_enable_i,
  input  bus_evt_t    bus_evt_i,
  input  phy_rsp_t    phy_rsp_i,
  input  addr_match_t match_i,
  input  logic        end_xfer_i,
  input  logic        tx_desc_avail_i,
  input  logic        tx_fifo_rvalid_i,
  input  logic        tx_last_byte_i,
  input  logic        is_ccc_done_i,
  input  logic        is_next_ccc_i,
  output logic        rx_req_byte_o,
  output logic        rx_req_bit_o,
  output tx_src_e     tx_src_o,
  output logic        tx_pop_o,
  output logic        addr_capture_o,
  output logic        check_f_o,
  output logic        check_s_o,
  output logic        data_done_o,
  output logic        tbit_done_o,
  output logic        write_entry_o,
  output logic        rx_clear_o,
  output logic        rx_last_byte_o,
  output logic        ccc_valid_o,
  output byte_t       ccc_o,
  output logic        target_idle_o,
  output logic        target_transmitting_o,
  output logic        event_target_nack_o,
  output logic        tx_pr_start_o,
  output logic        tx_pr_abort_o
);

  target_state_e state_q, state_d;
  byte_t         ccc_q;
  logic          start_det;
  logic          rx_done;
  logic          tx_done;
  logic          hit;

  assign start_det = bus_evt_i.start | bus_evt_i.rstart;
  assign rx_done   = phy_rsp_i.rx_done;
  assign tx_done   = phy_rsp_i.tx_done;
  assign hit       = match_i.ours | match_i.virt;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (target_enable_i && start_det) state_d = RxFByte;
      end
      RxFByte: begin
        if (rx_done) state_d = CheckFByte;
      end
      CheckFByte: begin
        // Read without a descriptor is not acknowledged
        if ((match_i.bcast || hit) && !(match_i.rnw && !tx_desc_avail_i)) begin
          state_d = TxAckFByte;
        end else begin
          state_d = Wait;
        end
      end
      TxAckFByte: begin
        if (tx_done) begin
          if (match_i.bcast) state_d = RxSByte;
          else if (match_i.rnw) state_d = TxPReadData;
          else state_d = RxPWriteData;
        end
      end
      // After 7E/W either a CCC follows or a repeated start with a direct address
      RxSByte: begin
        if (start_det) state_d = RxSByteRepeated;
        else if (rx_done) state_d = DoCCC;
      end
      RxSByteRepeated: begin
        if (rx_done) state_d = CheckSByte;
      end
      CheckSByte: begin
        if (hit && (tx_desc_avail_i || !match_i.rnw)) state_d = TxAckSByte;
        else state_d = Wait;
      end
      TxAckSByte: begin
        if (tx_done) begin
          if (match_i.rnw) state_d = TxPReadData;
          else state_d = RxPWriteData;
        end
      end
      RxPWriteData: begin
        if (start_det) state_d = RxFByte;
        else if (rx_done) state_d = RxPWriteTbit;
      end
      RxPWriteTbit: begin
        if (start_det) state_d = RxFByte;
        else if (rx_done) state_d = RxPWriteData;
      end
      TxPReadData: begin
        if (start_det) state_d = RxFByte;
        else if (tx_done) state_d = TxPReadTbit;
      end
      TxPReadTbit: begin
        if (start_det) begin
          state_d = RxFByte;
        end else if (tx_done) begin
          // Keep reading while data remains and the last byte has not gone out
          if ((tx_fifo_rvalid_i || tx_last_byte_i) && !end_xfer_i) state_d = TxPReadData;
          else state_d = Wait;
        end
      end
      Wait: begin
        if (start_det) state_d = RxFByte;
      end
      DoCCC: begin
        if (is_ccc_done_i) state_d = DoneCCC;
        else if (is_next_ccc_i) state_d = RxSByte;
      end
      DoneCCC: state_d = Idle;
      default: state_d = Idle;
    endcase
    if (bus_evt_i.stop) state_d = Idle;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Command code of a broadcast transfer for the CCC sub-machine
  always_ff @(posedge clk_i) begin
    if (state_q == RxSByte && rx_done && !start_det) begin
      ccc_q <= phy_rsp_i.rx_data;
    end
  end

  always_comb begin
    case (state_q)
      TxAckFByte, TxAckSByte: tx_src_o = TxAck;
      TxPReadData:            tx_src_o = TxData;
      TxPReadTbit:            tx_src_o = TxTbit;
      default:                tx_src_o = TxNone;
    endcase
  end

  assign rx_req_byte_o = (state_q inside {RxFByte, RxSByte, RxSByteRepeated, RxPWriteData})
                         & ~start_det;
  assign rx_req_bit_o  = (state_q == RxPWriteTbit) & ~start_det;

  assign tx_pop_o = (state_q != TxPReadData) & (state_d == TxPReadData);

  assign addr_capture_o = rx_done & (state_q inside {RxFByte, RxSByteRepeated});
  assign check_f_o      = (state_q == CheckFByte);
  assign check_s_o      = (state_q == CheckSByte);

  assign data_done_o    = (state_q == RxPWriteData) & rx_done;
  assign tbit_done_o    = (state_q == RxPWriteTbit) & rx_done;
  assign write_entry_o  = (state_q == RxPWriteTbit) & (state_d == RxPWriteData);
  assign rx_clear_o     = (state_q inside {Idle, RxFByte});
  assign rx_last_byte_o = (state_q == RxPWriteData) & (state_d inside {RxFByte, Idle});

  assign ccc_valid_o = (state_q == DoCCC);
  assign ccc_o       = ccc_q;

  assign target_idle_o         = (state_q == Idle);
  assign target_transmitting_o = (state_q inside {TxAckFByte, TxAckSByte, TxPReadData,
                                                  TxPReadTbit});

  assign event_target_nack_o = (state_q != Wait) & (state_d == Wait);

  // Private read begins once the address is known to be ours
  assign tx_pr_start_o = ((check_f_o & ~match_i.bcast) | check_s_o) & hit & match_i.rnw;
  assign tx_pr_abort_o = (state_q inside {TxPReadData, TxPReadTbit})
                         & (start_det | bus_evt_i.stop);

endmodule

/* logic/i3c_target_ctrl.sv */
// Top level of the I3C/I2C target primary control path
// Connects the FSM, address decoder and RX/TX data paths to PHY, FIFOs and CCC logic
`timescale 1ns/1ps

module i3c_target_ctrl
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      target_enable_i,
  input  bus_evt_t  bus_evt_i,
  input  phy_rsp_t  phy_rsp_i,
  output phy_req_t  phy_req_o,
  input  addr_cfg_t own_cfg_i,
  input  addr_cfg_t virt_cfg_i,
  input  logic      tx_desc_avail_i,
  input  logic      tx_fifo_rvalid_i,
  input  logic      tx_last_byte_i,
  input  byte_t     tx_fifo_rdata_i,
  output logic      tx_fifo_rready_o,
  input  logic      rx_fifo_wready_i,
  output logic      rx_fifo_wvalid_o,
  output byte_t     rx_fifo_wdata_o,
  output logic      rx_last_byte_o,
  output logic      parity_err_o,
  output logic      rx_overflow_err_o,
  output byte_t     ccc_o,
  output logic      ccc_valid_o,
  input  logic      is_ccc_done_i,
  input  logic      is_next_ccc_i,
  output byte_t     last_addr_o,
  output logic      last_addr_valid_o,
  output logic      virtual_device_sel_o,
  output logic      xfer_in_progress_o,
  output logic      target_idle_o,
  output logic      target_transmitting_o,
  output logic      event_target_nack_o,
  output logic      tx_pr_start_o,
  output logic      tx_pr_abort_o
);

  addr_match_t match;
  tx_src_e     tx_src;
  byte_t       tx_value;
  logic        rx_req_byte, rx_req_bit, tx_req_byte, tx_req_bit;
  logic        tx_pop, end_xfer;
  logic        addr_capture, check_f, check_s;
  logic        data_done, tbit_done, write_entry, rx_clear;

  i3c_target_fsm u_fsm (
    .clk_i, .rst_ni, .target_enable_i, .bus_evt_i, .phy_rsp_i,
    .match_i(match), .end_xfer_i(end_xfer),
    .tx_desc_avail_i, .tx_fifo_rvalid_i, .tx_last_byte_i, .is_ccc_done_i, .is_next_ccc_i,
    .rx_req_byte_o(rx_req_byte), .rx_req_bit_o(rx_req_bit),
    .tx_src_o(tx_src), .tx_pop_o(tx_pop),
    .addr_capture_o(addr_capture), .check_f_o(check_f), .check_s_o(check_s),
    .data_done_o(data_done), .tbit_done_o(tbit_done),
    .write_entry_o(write_entry), .rx_clear_o(rx_clear),
    .rx_last_byte_o, .ccc_valid_o, .ccc_o, .target_idle_o, .target_transmitting_o,
    .event_target_nack_o, .tx_pr_start_o, .tx_pr_abort_o
  );

  i3c_addr_decoder u_addr_decoder (
    .clk_i, .rst_ni, .rx_data_i(phy_rsp_i.rx_data),
    .addr_capture_i(addr_capture), .check_f_i(check_f), .check_s_i(check_s),
    .idle_i(target_idle_o), .start_i(bus_evt_i.start | bus_evt_i.rstart),
    .own_cfg_i, .virt_cfg_i, .match_o(match),
    .last_addr_o, .last_addr_valid_o, .virtual_device_sel_o, .xfer_in_progress_o
  );

  i3c_rx_path u_rx_path (
    .clk_i, .rst_ni, .rx_data_i(phy_rsp_i.rx_data),
    .data_done_i(data_done), .tbit_done_i(tbit_done),
    .write_entry_i(write_entry), .rx_clear_i(rx_clear),
    .rx_fifo_wready_i, .rx_fifo_wvalid_o, .rx_fifo_wdata_o, .parity_err_o, .rx_overflow_err_o
  );

  i3c_tx_path u_tx_path (
    .clk_i, .rst_ni, .tx_src_i(tx_src), .tx_pop_i(tx_pop), .tx_fifo_rdata_i,
    .tx_done_i(phy_rsp_i.tx_done), .tx_last_byte_i,
    .tx_value_o(tx_value), .tx_req_byte_o(tx_req_byte), .tx_req_bit_o(tx_req_bit),
    .end_xfer_o(end_xfer)
  );

  // Receive requests come from the FSM, transmit side from the TX path
  assign phy_req_o.rx_req_byte = rx_req_byte;
  assign phy_req_o.rx_req_bit  = rx_req_bit;
  assign phy_req_o.tx_req_byte = tx_req_byte;
  assign phy_req_o.tx_req_bit  = tx_req_bit;
  assign phy_req_o.tx_value    = tx_value;

  assign tx_fifo_rready_o = tx_pop;

endmodule

/* bench/tb_cases.svh */
// Test table and per-cycle PHY/FIFO/CCC model for the I3C target testbench
// Included inside the testbench module where it uses the DUT signals and bookkeeping variables
localparam int NumRows = 8;

// Byte lists are left aligned with item 0 in the top byte
string       names[NumRows];
addr_cfg_t   own_cfgs[NumRows];
addr_cfg_t   virt_cfgs[NumRows];
logic [63:0] rx_lists[NumRows];
int          rx_ns[NumRows];
logic [63:0] tx_lists[NumRows];
int          tx_ns[NumRows];
logic        descs[NumRows];
logic        wreadys[NumRows];
logic [63:0] fifo_exps[NumRows];
int          fifo_ns[NumRows];
logic [63:0] txv_exps[NumRows];
int          txv_ns[NumRows];
logic        xfer_exps[NumRows];
logic        vsel_exps[NumRows];
int          nack_exps[NumRows];
int          par_exps[NumRows];
int          ovf_exps[NumRows];
int          pop_exps[NumRows];
int          last_exps[NumRows];
int          prs_exps[NumRows];
logic        ccc_exps[NumRows];
byte_t       ccc_codes[NumRows];

function automatic addr_cfg_t make_cfg(addr_t sta, logic sv, addr_t dyn, logic dv);
  make_cfg = {sta, sv, dyn, dv};
endfunction

function automatic byte_t list_byte(logic [63:0] list, int idx);
  return list[63 - 8 * idx -: 8];
endfunction

task automatic fill_table();
  names = '{"write_dyn", "parity_err", "rx_overflow", "private_read",
            "nack_mismatch", "nack_no_desc", "ccc_broadcast", "virt_write"};
  own_cfgs = '{make_cfg(7'h20, 1, 7'h31, 1), make_cfg(7'h20, 1, 0, 0),
               make_cfg(7'h20, 1, 0, 0), make_cfg(7'h20, 1, 0, 0),
               make_cfg(7'h20, 1, 0, 0), make_cfg(7'h20, 1, 0, 0),
               make_cfg(7'h20, 1, 0, 0), make_cfg(7'h20, 1, 0, 0)};
  virt_cfgs = '{'0, '0, '0, '0, '0, '0, '0, make_cfg(7'h45, 1, 0, 0)};
  // Address byte, then data byte and T-bit pairs for writes
  rx_lists = '{64'h62A5_013C_0107_0000, 64'h4081_015A_0000_0000,
               64'h4081_0103_0100_0000, 64'h4100_0000_0000_0000,
               64'h6600_0000_0000_0000, 64'h4100_0000_0000_0000,
               64'hFC07_0000_0000_0000, 64'h8AC3_0100_0000_0000};
  rx_ns    = '{7, 5, 5, 1, 1, 1, 2, 3};
  tx_lists = '{0, 0, 0, 64'h5CE1_0000_0000_0000, 0, 64'h9900_0000_0000_0000, 0, 0};
  tx_ns    = '{0, 0, 0, 2, 0, 1, 0, 0};
  descs    = '{0, 0, 0, 1, 0, 0, 0, 0};
  wreadys  = '{1, 1, 0, 1, 1, 1, 1, 1};
  fifo_exps = '{64'hA53C_0700_0000_0000, 64'h8100_0000_0000_0000,
                64'h8100_0000_0000_0000, 0, 0, 0, 0, 64'hC300_0000_0000_0000};
  fifo_ns   = '{3, 1, 1, 0, 0, 0, 0, 1};
  // Transmit stream with the ACK first
  txv_exps  = '{0, 0, 0, 64'h005C_01E1_0000_0000, 0, 0, 0, 0};
  txv_ns    = '{1, 1, 1, 5, 0, 0, 1, 1};
  xfer_exps = '{1, 1, 1, 1, 0, 1, 0, 1};
  vsel_exps = '{0, 0, 0, 0, 0, 0, 0, 1};
  nack_exps = '{0, 0, 0, 1, 1, 1, 0, 0};
  par_exps  = '{0, 1, 0, 0, 0, 0, 0, 0};
  ovf_exps  = '{0, 0, 1, 0, 0, 0, 0, 0};
  pop_exps  = '{0, 0, 0, 2, 0, 0, 0, 0};
  // A write ends with its last byte marked, a read to us announces itself
  last_exps = '{1, 1, 1, 0, 0, 0, 0, 1};
  prs_exps  = '{0, 0, 0, 1, 0, 1, 0, 0};
  ccc_exps  = '{0, 0, 0, 0, 0, 0, 1, 0};
  ccc_codes = '{0, 0, 0, 0, 0, 0, 8'h07, 0};
endtask

// Drives just after the rising edge and observes at the falling edge
task automatic step_cycle();
  @(posedge clk_i);
  #1;
  bus_evt = '0;
  phy_rsp = '0;
  own_cfg = own_cfgs[row];
  virt_cfg = virt_cfgs[row];
  tx_desc_avail = descs[row];
  rx_fifo_wready = draining ? 1'b1 : wreadys[row];
  bus_evt.start = start_pend;
  bus_evt.stop = stop_pend;
  start_pend = 0;
  stop_pend = 0;
  if (pop_pending) tx_head++;
  pop_pending = 0;
  tx_fifo_rvalid = (tx_head < tx_ns[row]);
  tx_fifo_rdata = tx_fifo_rvalid ? list_byte(tx_lists[row], tx_head) : 8'h00;
  tx_last_byte = (tx_ns[row] - tx_head == 1);
  is_ccc_done = ccc_pulse;
  ccc_pulse = 0;
  if (busy) begin
    wait_cnt--;
    if (wait_cnt == 0) begin
      busy = 0;
      skip = 1;
      if (rsp_is_rx) begin
        phy_rsp.rx_done = 1'b1;
        phy_rsp.rx_data = list_byte(rx_lists[row], rx_ptr);
        rx_ptr++;
      end else begin
        phy_rsp.tx_done = 1'b1;
      end
    end
  end
  @(negedge clk_i);
  if (rx_fifo_wvalid && rx_fifo_wready) fifo_seen.push_back(rx_fifo_wdata);
  if (tx_fifo_rready) begin
    pop_cnt++;
    pop_pending = 1;
  end
  nack_cnt += nack;
  par_cnt += parity_err;
  ovf_cnt += rx_overflow_err;
  last_cnt += rx_last_byte;
  prs_cnt += pr_start;
  abort_cnt += pr_abort;
  xfer_seen |= xfer;
  vsel_seen |= vsel;
  txing_seen |= target_tx;
  if (last_addr_valid && !target_idle) addr_snap = last_addr;
  // CCC request stays up until the sub-machine reports done
  if (is_ccc_done) expect_eq("ccc_valid at done", 1, ccc_valid);
  if (ccc_valid && !ccc_ack) begin
    ccc_ack = 1;
    ccc_pulse = 1;
    ccc_seen = 1;
    ccc_code = ccc;
  end
  if (skip) begin
    skip = 0;
  end else if (!busy) begin
    if ((phy_req.rx_req_byte || phy_req.rx_req_bit) && rx_ptr < rx_ns[row]) begin
      busy = 1;
      rsp_is_rx = 1;
      wait_cnt = $urandom_range(4, 1);
    end else if (phy_req.tx_req_byte || phy_req.tx_req_bit) begin
      busy = 1;
      rsp_is_rx = 0;
      wait_cnt = $urandom_range(4, 1);
      tx_seen.push_back(phy_req.tx_value);
    end
  end
  // Nothing left to answer and no request or CCC hand-off open
  if (rx_ptr == rx_ns[row] && !busy && !ccc_valid && !ccc_pulse &&
      !phy_req.tx_req_byte && !phy_req.tx_req_bit) quiet_cnt++;
  else quiet_cnt = 0;
endtask

/* bench/tb_i3c_target_ctrl.sv */
// Testbench for the I3C target control path
// Runs the case table row by row against the DUT and prints the result
`timescale 1ns/1ps

module tb_i3c_target_ctrl
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
();

  logic clk_i, rst_ni, target_enable;
  bus_evt_t bus_evt;
  phy_rsp_t phy_rsp;
  phy_req_t phy_req;
  addr_cfg_t own_cfg, virt_cfg;
  logic tx_desc_avail, tx_fifo_rvalid, tx_last_byte, tx_fifo_rready;
  byte_t tx_fifo_rdata, rx_fifo_wdata, ccc, last_addr;
  logic rx_fifo_wready, rx_fifo_wvalid, rx_last_byte, parity_err, rx_overflow_err;
  logic ccc_valid, is_ccc_done, is_next_ccc, last_addr_valid, vsel, xfer;
  logic target_idle, target_tx, nack, pr_start, pr_abort;

  // Model and bookkeeping state
  int row, wait_cnt, rx_ptr, tx_head, quiet_cnt, row_errs, errors, failed_rows;
  int nack_cnt, par_cnt, ovf_cnt, pop_cnt, cycles, limit;
  int last_cnt, prs_cnt, abort_cnt;
  bit busy, rsp_is_rx, skip, pop_pending, ccc_ack, ccc_pulse;
  bit start_pend, stop_pend, draining, xfer_seen, vsel_seen, ccc_seen, txing_seen;
  byte_t ccc_code, addr_snap;
  byte_t fifo_seen[$];
  byte_t tx_seen[$];

  `include "tb_cases.svh"

  i3c_target_ctrl u_i3c_target_ctrl (
    .clk_i(clk_i), .rst_ni(rst_ni), .target_enable_i(target_enable),
    .bus_evt_i(bus_evt), .phy_rsp_i(phy_rsp), .phy_req_o(phy_req),
    .own_cfg_i(own_cfg), .virt_cfg_i(virt_cfg), .tx_desc_avail_i(tx_desc_avail),
    .tx_fifo_rvalid_i(tx_fifo_rvalid), .tx_last_byte_i(tx_last_byte),
    .tx_fifo_rdata_i(tx_fifo_rdata), .tx_fifo_rready_o(tx_fifo_rready),
    .rx_fifo_wready_i(rx_fifo_wready), .rx_fifo_wvalid_o(rx_fifo_wvalid),
    .rx_fifo_wdata_o(rx_fifo_wdata), .rx_last_byte_o(rx_last_byte),
    .parity_err_o(parity_err), .rx_overflow_err_o(rx_overflow_err),
    .ccc_o(ccc), .ccc_valid_o(ccc_valid), .is_ccc_done_i(is_ccc_done),
    .is_next_ccc_i(is_next_ccc), .last_addr_o(last_addr),
    .last_addr_valid_o(last_addr_valid), .virtual_device_sel_o(vsel),
    .xfer_in_progress_o(xfer), .target_idle_o(target_idle),
    .target_transmitting_o(target_tx), .event_target_nack_o(nack),
    .tx_pr_start_o(pr_start), .tx_pr_abort_o(pr_abort)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic expect_eq(string what, int exp_v, int act_v);
    assert (exp_v == act_v) else begin
      $display("Error %s %s: expected %0h, actual %0h", names[row], what, exp_v, act_v);
      row_errs++;
    end
  endtask

  task automatic check_row();
    int i;
    expect_eq("fifo count", fifo_ns[row], fifo_seen.size());
    for (i = 0; i < fifo_ns[row] && i < fifo_seen.size(); i++)
      expect_eq($sformatf("fifo[%0d]", i), list_byte(fifo_exps[row], i), fifo_seen[i]);
    expect_eq("tx count", txv_ns[row], tx_seen.size());
    for (i = 0; i < txv_ns[row] && i < tx_seen.size(); i++)
      expect_eq($sformatf("tx[%0d]", i), list_byte(txv_exps[row], i), tx_seen[i]);
    expect_eq("nack pulses", nack_exps[row], nack_cnt);
    expect_eq("parity pulses", par_exps[row], par_cnt);
    expect_eq("overflow pulses", ovf_exps[row], ovf_cnt);
    expect_eq("pops", pop_exps[row], pop_cnt);
    expect_eq("rx_last_byte pulses", last_exps[row], last_cnt);
    expect_eq("tx_pr_start pulses", prs_exps[row], prs_cnt);
    expect_eq("tx_pr_abort pulses", 0, abort_cnt);
    expect_eq("transmitting seen", txv_ns[row] != 0, txing_seen);
    expect_eq("xfer_in_progress", xfer_exps[row], xfer_seen);
    expect_eq("virtual_sel", vsel_exps[row], vsel_seen);
    expect_eq("last_addr", list_byte(rx_lists[row], 0), addr_snap);
    expect_eq("ccc_valid seen", ccc_exps[row], ccc_seen);
    if (ccc_exps[row]) expect_eq("ccc code", ccc_codes[row], ccc_code);
    expect_eq("target_idle", 1, target_idle);
  endtask

  task automatic run_row(int idx);
    row = idx;
    {busy, skip, pop_pending, ccc_ack, ccc_pulse} = '0;
    {xfer_seen, vsel_seen, ccc_seen, txing_seen} = '0;
    {rx_ptr, tx_head, nack_cnt, par_cnt, ovf_cnt, pop_cnt, row_errs} = '0;
    {last_cnt, prs_cnt, abort_cnt} = '0;
    addr_snap = 8'h00;
    ccc_code = 8'h00;
    fifo_seen.delete();
    tx_seen.delete();
    start_pend = 1;
    quiet_cnt = 0;
    while (quiet_cnt < 3) step_cycle();
    // A finished CCC hand-off returns to idle without a stop
    if (ccc_exps[row]) expect_eq("idle after ccc", 1, target_idle);
    stop_pend = 1;
    draining = 1;
    repeat (4) step_cycle();
    draining = 0;
    check_row();
    errors += row_errs;
    if (row_errs != 0) failed_rows++;
    $display("Test %s: %s", names[row], (row_errs == 0) ? "passed" : "failed");
  endtask

  initial begin
    int total;
    void'($urandom(71363));
    {target_enable, tx_desc_avail, tx_fifo_rvalid, tx_last_byte} = '0;
    {rx_fifo_wready, is_ccc_done, is_next_ccc} = '0;
    bus_evt = '0;
    phy_rsp = '0;
    own_cfg = '0;
    virt_cfg = '0;
    tx_fifo_rdata = '0;
    {row, limit, errors, failed_rows, draining, start_pend, stop_pend} = '0;
    rst_ni = 1'b0;
    fill_table();
    total = 0;
    for (int r = 0; r < NumRows; r++) total += rx_ns[r] + tx_ns[r];
    limit = 40 * total;
    target_enable = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int r = 0; r < NumRows; r++) run_row(r);
    $display("Tests run: %0d, failed: %0d, errors: %0d", NumRows, failed_rows, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+bench
logic/i3c_bus_pkg.sv
logic/i3c_target_pkg.sv
logic/i3c_addr_decoder.sv
logic/i3c_rx_path.sv
logic/i3c_tx_path.sv
logic/i3c_target_fsm.sv
logic/i3c_target_ctrl.sv
bench/tb_i3c_target_ctrl.sv
